//--- Makefile
# Verilator build and run of the ADXL reader testbench

VERILATOR ?= verilator
TOP       ?= adxl_rd_tb
FLIST     ?= adxl_rd.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- adxl_rd.f
rtl/adxl_pkg.sv
rtl/adxl_seq_ctrl.sv
rtl/adxl_spi_port.sv
rtl/adxl_tag_fifo.sv
rtl/adxl_ch1_buf.sv
rtl/adxl_bram_buf.sv
rtl/adxl_rd_top.sv
tb/adxl_sensor_model.sv
tb/adxl_rd_tb.sv

//--- rtl/adxl_bram_buf.sv
// ADXL reader buffer RAM
// sequential byte writes from chip 0 or chip 1 replay, registered host read
`timescale 1ns/1ps

module adxl_bram_buf
#(
  parameter int buf_addr_bits = 5
)
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     x,       // write address back to 0
  input  logic                     wr0,
  input  logic [7:0]               byte0,
  input  logic                     rwr,
  input  logic [7:0]               rbyte,
  input  logic [buf_addr_bits-1:0] rd_addr,
  output logic [7:0]               rd_data,
  output logic [buf_addr_bits-1:0] wr_count
);

  logic [7:0]               mem [0:2**buf_addr_bits-1];
  logic [buf_addr_bits-1:0] waddr;
  logic                     we;
  logic [7:0]               wdata;

  assign we    = wr0 | rwr;            // sources never active together
  assign wdata = rwr ? rbyte : byte0;

  always_ff @(posedge clk)
  begin
    if (we)
      mem[waddr] <= wdata;
    rd_data <= mem[rd_addr];           // one clk read latency
  end

  always_ff @(posedge clk)
  begin
    if (rst || x)
      waddr <= '0;
    else if (we)
      waddr <= waddr + 1'b1;
  end

  assign wr_count = waddr;

endmodule

//--- rtl/adxl_ch1_buf.sv
// ADXL reader chip 1 buffer
// holds chip 1 data bytes, replays them to the RAM after the frame ends
`timescale 1ns/1ps

module adxl_ch1_buf
(
  input  logic       clk,
  input  logic       rst,
  input  logic       frame_start,
  input  logic       frame_done,
  input  logic [3:0] len_q,
  input  logic [7:0] byte1,
  input  logic       wr1,
  output logic [7:0] rbyte,
  output logic       rwr
);
  import adxl_pkg::*;

  localparam int ptr_w = $clog2(max_data_bytes);

  logic [7:0]       mem [0:max_data_bytes-1];
  logic [ptr_w-1:0] wptr;
  logic [ptr_w-1:0] rptr;
  logic [3:0]       cnt;  // replay bytes left after the current one

  always_ff @(posedge clk)
  begin
    if (wr1)
      mem[wptr] <= byte1;
    if (frame_done)
      rbyte <= mem[0];
    else if (cnt != 4'd0)
      rbyte <= mem[rptr];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wptr <= '0;
      rptr <= '0;
      cnt  <= '0;
      rwr  <= 1'b0;
    end
    else
    begin
      if (frame_start)
        wptr <= '0;
      else if (wr1)
        wptr <= wptr + 1'b1;
      if (frame_done)
      begin
        rwr  <= 1'b1;           // byte 0 goes out right away
        rptr <= ptr_w'(1);
        cnt  <= len_q - 4'd2;   // len-1 pulses in total
      end
      else if (cnt != 4'd0)
      begin
        rwr  <= 1'b1;
        rptr <= rptr + 1'b1;
        cnt  <= cnt - 1'b1;
      end
      else
        rwr <= 1'b0;
    end
  end

endmodule

//--- rtl/adxl_pkg.sv
// ADXL reader shared constants
// index layout, frame phases and tag characters
package adxl_pkg;

  // transaction index: upper nibble byte count, lower nibble phase in byte
  parameter int idx_w = 8;

  // absolute index values at frame start
  parameter logic [idx_w-1:0] ph_csn_lo  = 8'd1; // chip select falls
  parameter logic [idx_w-1:0] ph_sclk_on = 8'd3; // spi clock starts

  // low nibble phases, combined with len as {len, phase}
  parameter logic [3:0] ph_sclk_off = 4'h4; // spi clock stops
  parameter logic [3:0] ph_csn_hi   = 4'h5; // chip select rises
  parameter logic [3:0] ph_end      = 4'h6; // frame finished, idle

  // 6-bit tag characters
  parameter logic [5:0] tag_pulse_char = 6'h21; // "!"
  parameter logic [5:0] tag_idle_char  = 6'h20; // space

  // chip 1 local buffer depth, max len minus command byte
  parameter int max_data_bytes = 9;

endpackage

//--- rtl/adxl_rd_top.sv
// ADXL dual accelerometer reader, top level
// sequencer, SPI port, tag FIFO, chip 1 buffer and buffer RAM
`timescale 1ns/1ps

module adxl_rd_top
#(
  parameter bit tag_enable    = 1'b0,
  parameter int tag_addr_bits = 4,
  parameter int buf_addr_bits = 5
)
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clk_en,
  input  logic                     sync,
  input  logic [7:0]               cmd,
  input  logic [3:0]               len,
  input  logic                     direct,
  input  logic                     tag_pulse,
  input  logic                     tag_en,
  input  logic [5:0]               tag,
  input  logic                     sclk_phase,
  input  logic                     sclk_polarity,
  input  logic                     host_mosi,
  input  logic                     host_sclk,
  input  logic                     host_csn,
  input  logic                     adxl0_miso,
  input  logic                     adxl1_miso,
  input  logic [buf_addr_bits-1:0] rd_addr,
  output logic                     adxl_mosi,
  output logic                     adxl_sclk,
  output logic                     adxl_csn,
  output logic                     host_miso,
  output logic                     direct_en,
  output logic [7:0]               rd_data,
  output logic [buf_addr_bits-1:0] wr_count
);
  import adxl_pkg::*;

  logic [idx_w-1:0] index;
  logic [7:0]       cmd_q;
  logic [3:0]       len_q;
  logic             csn, sclk_en;
  logic             frame_start, frame_done;
  logic [5:0]       tag_data;
  logic [7:0]       byte0, byte1, rbyte;
  logic             wr0, wr1, rwr, x;

  adxl_seq_ctrl u_seq
  (
    .clk(clk), .rst(rst), .clk_en(clk_en), .sync(sync), .direct(direct),
    .cmd(cmd), .len(len), .index(index), .cmd_q(cmd_q), .len_q(len_q),
    .csn(csn), .sclk_en(sclk_en), .frame_start(frame_start),
    .frame_done(frame_done), .direct_en(direct_en)
  );

  adxl_spi_port #(.tag_enable(tag_enable)) u_spi
  (
    .clk(clk), .rst(rst), .clk_en(clk_en), .index(index), .len_q(len_q),
    .cmd_q(cmd_q), .csn(csn), .sclk_en(sclk_en), .sclk_phase(sclk_phase),
    .sclk_polarity(sclk_polarity), .tag_data(tag_data), .direct_en(direct_en),
    .host_mosi(host_mosi), .host_sclk(host_sclk), .host_csn(host_csn),
    .adxl0_miso(adxl0_miso), .adxl1_miso(adxl1_miso), .adxl_mosi(adxl_mosi),
    .adxl_sclk(adxl_sclk), .adxl_csn(adxl_csn), .host_miso(host_miso),
    .byte0(byte0), .wr0(wr0), .byte1(byte1), .wr1(wr1), .x(x)
  );

  adxl_tag_fifo #(.tag_addr_bits(tag_addr_bits)) u_tag
  (
    .clk(clk), .rst(rst), .tag_en(tag_en), .tag(tag), .tag_pulse(tag_pulse),
    .frame_start(frame_start), .tag_data(tag_data)
  );

  adxl_ch1_buf u_ch1
  (
    .clk(clk), .rst(rst), .frame_start(frame_start), .frame_done(frame_done),
    .len_q(len_q), .byte1(byte1), .wr1(wr1), .rbyte(rbyte), .rwr(rwr)
  );

  adxl_bram_buf #(.buf_addr_bits(buf_addr_bits)) u_ram
  (
    .clk(clk), .rst(rst), .x(x), .wr0(wr0), .byte0(byte0), .rwr(rwr),
    .rbyte(rbyte), .rd_addr(rd_addr), .rd_data(rd_data), .wr_count(wr_count)
  );

endmodule

//--- rtl/adxl_seq_ctrl.sv
// ADXL reader sequencer
// runs the frame index, chip select, clock enable and direct-mode grant
`timescale 1ns/1ps

module adxl_seq_ctrl
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       clk_en,      // 2x spi bit rate tick
  input  logic                       sync,        // frame request, seen only when idle
  input  logic                       direct,      // direct mode request
  input  logic [7:0]                 cmd,
  input  logic [3:0]                 len,         // bytes incl command byte
  output logic [adxl_pkg::idx_w-1:0] index,
  output logic [7:0]                 cmd_q,
  output logic [3:0]                 len_q,
  output logic                       csn,
  output logic                       sclk_en,
  output logic                       frame_start,
  output logic                       frame_done,
  output logic                       direct_en
);
  import adxl_pkg::*;

  logic [idx_w-1:0] end_idx;  // idle position for current length
  logic [idx_w-1:0] index_nx;
  logic             at_end;
  logic             start;

  assign end_idx  = {len_q, ph_end};
  assign index_nx = index + 1'b1;
  assign at_end   = index == end_idx;
  assign start    = at_end & sync & ~direct_en; // no frames while host owns the bus

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      index       <= {4'd10, ph_end}; // come up idle, as if a frame just ended
      len_q       <= 4'd10;
      frame_start <= 1'b0;
      frame_done  <= 1'b0;
    end
    else
    begin
      frame_start <= 1'b0;
      frame_done  <= 1'b0;
      if (start)
      begin
        index       <= '0;
        len_q       <= len;
        frame_start <= 1'b1; // tag latch, chip 1 buffer rewind
      end
      else if (!at_end && clk_en)
      begin
        index      <= index_nx;
        frame_done <= index_nx == end_idx; // high in first idle cycle
      end
    end
  end

  // command word is only payload for the mosi shifter
  always_ff @(posedge clk)
  begin
    if (start)
      cmd_q <= cmd;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      csn       <= 1'b1;
      sclk_en   <= 1'b0;
      direct_en <= 1'b0;
    end
    else
    begin
      if (clk_en)
      begin
        if (index == ph_csn_lo)
          csn <= 1'b0;
        else if (index == {len_q, ph_csn_hi})
          csn <= 1'b1;
        if (index == ph_sclk_on)
          sclk_en <= 1'b1;
        else if (index == {len_q, ph_sclk_off})
          sclk_en <= 1'b0;
      end
      // grant changes only between frames, csn already high here
      if (at_end && !start)
        direct_en <= direct;
    end
  end

endmodule

//--- rtl/adxl_spi_port.sv
// ADXL reader SPI port
// sclk generation, mosi/miso shifters, tag bit merge and direct pin mux
`timescale 1ns/1ps

module adxl_spi_port
#(
  parameter bit tag_enable = 1'b0 // 1: put tag bits in odd data byte lsb
)
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       clk_en,
  input  logic [adxl_pkg::idx_w-1:0] index,
  input  logic [3:0]                 len_q,
  input  logic [7:0]                 cmd_q,
  input  logic                       csn,
  input  logic                       sclk_en,
  input  logic                       sclk_phase,    // 0 for adxl355
  input  logic                       sclk_polarity, // 0 for adxl355
  input  logic [5:0]                 tag_data,
  input  logic                       direct_en,
  input  logic                       host_mosi,
  input  logic                       host_sclk,
  input  logic                       host_csn,
  input  logic                       adxl0_miso,
  input  logic                       adxl1_miso,
  output logic                       adxl_mosi,
  output logic                       adxl_sclk,
  output logic                       adxl_csn,
  output logic                       host_miso,
  output logic [7:0]                 byte0,
  output logic                       wr0,
  output logic [7:0]                 byte1,
  output logic                       wr1,
  output logic                       x
);

  logic       sclk_q;
  logic [7:0] mosi_sr;
  logic [7:0] onehot;           // bit 7 marks the last bit of a byte
  logic [7:0] miso0_sr, miso1_sr;
  logic [7:0] shin0, shin1;     // shifter value incl the bit sampled now
  logic       byte_tick, load_tick, data_tick;
  logic       tag_hit, tag_bit0, tag_bit1;
  logic       wr_pend, wr_q;

  assign byte_tick = clk_en & ~index[0]; // one bit per two ticks
  assign load_tick = index[7:1] == 7'd2; // start of command byte
  assign shin0     = {miso0_sr[6:0], adxl0_miso};
  assign shin1     = {miso1_sr[6:0], adxl1_miso};
  // byte 1 is the command echo and is dropped
  assign data_tick = byte_tick & onehot[7] & sclk_en &
                     (index[7:4] >= 4'd2) & (index[7:4] <= len_q);

  // data byte k ends at byte count k+2, so odd k 1,3,5 means count 3,5,7
  always_comb
  begin
    tag_hit  = 1'b0;
    tag_bit0 = 1'b0;
    tag_bit1 = 1'b0;
    if (tag_enable)
    begin
      case (index[7:4])
        4'd3:
        begin
          tag_hit  = 1'b1;
          tag_bit0 = tag_data[0];
          tag_bit1 = tag_data[3];
        end
        4'd5:
        begin
          tag_hit  = 1'b1;
          tag_bit0 = tag_data[1];
          tag_bit1 = tag_data[4];
        end
        4'd7:
        begin
          tag_hit  = 1'b1;
          tag_bit0 = tag_data[2];
          tag_bit1 = tag_data[5];
        end
        default:
        begin
          tag_hit = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      sclk_q <= sclk_polarity;
    else if (clk_en)
      sclk_q <= ((index[0] ^ sclk_phase) & sclk_en) ^ sclk_polarity;
  end

  always_ff @(posedge clk)
  begin
    if (byte_tick)
    begin
      mosi_sr  <= load_tick ? cmd_q : {mosi_sr[6:0], 1'b0}; // msb first
      miso0_sr <= shin0;
      miso1_sr <= shin1;
      if (onehot[7])
      begin
        byte0 <= tag_hit ? {shin0[7:1], tag_bit0} : shin0;
        byte1 <= tag_hit ? {shin1[7:1], tag_bit1} : shin1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      onehot  <= '0;
      wr_pend <= 1'b0;
      wr_q    <= 1'b0;
      x       <= 1'b0;
    end
    else
    begin
      if (byte_tick)
        onehot <= load_tick ? 8'h01 : {onehot[6:0], onehot[7]};
      x       <= data_tick & (index[7:4] == 4'd2); // first data byte only
      wr_pend <= data_tick;
      wr_q    <= wr_pend;                          // lands one clk after x
    end
  end

  assign wr0 = wr_q;
  assign wr1 = wr_q; // both chips complete a byte together

  // host takes the pins in direct mode
  assign adxl_csn  = direct_en ? host_csn  : csn;
  assign adxl_sclk = direct_en ? host_sclk : sclk_q;
  assign adxl_mosi = direct_en ? host_mosi : mosi_sr[7];
  assign host_miso = direct_en ? adxl0_miso : 1'b0;

endmodule

//--- rtl/adxl_tag_fifo.sv
// ADXL reader tag FIFO
// 6-bit tag characters with "!" pulse priority, one latched per frame
`timescale 1ns/1ps

module adxl_tag_fifo
#(
  parameter int tag_addr_bits = 4 // fifo holds 2**n chars
)
(
  input  logic       clk,
  input  logic       rst,
  input  logic       tag_en,      // push tag
  input  logic [5:0] tag,
  input  logic       tag_pulse,   // request "!" in next frame
  input  logic       frame_start,
  output logic [5:0] tag_data     // held for the whole frame
);
  import adxl_pkg::*;

  logic [5:0]               mem [0:2**tag_addr_bits-1];
  logic [tag_addr_bits-1:0] wptr;
  logic [tag_addr_bits-1:0] wptr_q; // lags one clk so head_q is valid
  logic [tag_addr_bits-1:0] rptr;
  logic [5:0]               head_q; // registered fifo head
  logic                     pulse_pend;
  logic                     empty;

  assign empty = wptr_q == rptr;

  always_ff @(posedge clk)
  begin
    if (tag_en)
      mem[wptr] <= tag;
    head_q <= mem[rptr];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wptr       <= '0;
      wptr_q     <= '0;
      rptr       <= '0;
      pulse_pend <= 1'b0;
      tag_data   <= tag_idle_char;
    end
    else
    begin
      wptr_q <= wptr;
      if (tag_en)
        wptr <= wptr + 1'b1; // overfill wraps silently
      if (tag_pulse)
        pulse_pend <= 1'b1;
      else if (frame_start)
        pulse_pend <= 1'b0;
      if (frame_start)
      begin
        if (pulse_pend)
          tag_data <= tag_pulse_char; // fifo left untouched
        else if (!empty)
        begin
          tag_data <= head_q;
          rptr     <= rptr + 1'b1;    // pop
        end
        else
          tag_data <= tag_idle_char;
      end
    end
  end

endmodule

//--- tb/adxl_rd_tb.sv
// ADXL reader testbench
// framed reads from two sensor models, tags and direct mode, RAM checked per frame
`timescale 1ns/1ps

module adxl_rd_tb;

  localparam int frame_clks  = (10 * 16 + 8) * 4;  // longest frame in clk cycles
  localparam int n_frames    = 16;                 // frames run by all tests
  localparam int cycle_limit = (n_frames + 2) * frame_clks + 2000;

  logic       clk = 1'b0;
  logic       rst = 1'b1;
  logic       clk_en = 1'b0;
  logic [1:0] div = 2'd0;
  logic       sync, direct, tag_pulse, tag_en;
  logic [7:0] cmd;
  logic [3:0] len;
  logic [5:0] tag;
  logic       sclk_phase, sclk_polarity;
  logic       host_mosi, host_sclk, host_csn;
  logic [4:0] rd_addr;
  logic       adxl_mosi, adxl_sclk, adxl_csn, host_miso, direct_en;
  logic       adxl0_miso, adxl1_miso;
  logic [7:0] rd_data, cmd_rx;
  logic [4:0] wr_count;
  logic [3:0] model_frame = 4'd0;

  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          failed = 0;
  int          test_err0 = 0;
  int          frame_n = 0;
  int          cycles = 0;
  logic [31:0] rnd = 32'd22;   // lcg state
  logic [5:0]  tag_q[$];       // characters the FIFO should hold
  logic        pulse_pending = 1'b0;

  adxl_rd_top #(.tag_enable(1'b1), .tag_addr_bits(4), .buf_addr_bits(5)) DUT
  (
    .clk(clk), .rst(rst), .clk_en(clk_en), .sync(sync), .cmd(cmd), .len(len),
    .direct(direct), .tag_pulse(tag_pulse), .tag_en(tag_en), .tag(tag),
    .sclk_phase(sclk_phase), .sclk_polarity(sclk_polarity), .host_mosi(host_mosi),
    .host_sclk(host_sclk), .host_csn(host_csn), .adxl0_miso(adxl0_miso),
    .adxl1_miso(adxl1_miso), .rd_addr(rd_addr), .adxl_mosi(adxl_mosi),
    .adxl_sclk(adxl_sclk), .adxl_csn(adxl_csn), .host_miso(host_miso),
    .direct_en(direct_en), .rd_data(rd_data), .wr_count(wr_count)
  );

  adxl_sensor_model u_sensors
  (
    .csn(adxl_csn), .sclk(adxl_sclk), .mosi(adxl_mosi), .frame_no(model_frame),
    .miso0(adxl0_miso), .miso1(adxl1_miso), .cmd_rx(cmd_rx)
  );

  always #50 clk = ~clk;  // 100 ns period

  always @(posedge clk)
  begin
    #1;
    div    = div + 2'd1;
    clk_en = div == 2'd3;  // one tick in four clk
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles == cycle_limit)
    begin
      $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
      $display(">>> FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // expected RAM word: chip 0 bytes first, then chip 1, tag in odd byte lsb
  function automatic logic [7:0] ref_byte(input int n, input int nlen,
                                          input logic [5:0] tchar, input int addr);
    logic       chip;
    int         k;
    logic [7:0] b;
    chip = addr >= nlen - 1;
    k    = chip ? addr - (nlen - 1) : addr;
    b    = 8'(16 * n + k) + (chip ? 8'h80 : 8'h00);
    if (k == 1 || k == 3 || k == 5)
      b[0] = chip ? tchar[(k - 1) / 2 + 3] : tchar[(k - 1) / 2];
    return b;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic push_tag(input logic [5:0] c);
    tag    = c;
    tag_en = 1'b1;
    step();
    tag_en = 1'b0;
    tag_q.push_back(c);
  endtask

  // one sync, wait for csn low then high, let the chip 1 replay finish, check RAM
  task automatic run_frame(input int n_len, input logic [7:0] n_cmd, input logic go_direct);
    logic [5:0] tchar;
    int         a;
    if (pulse_pending)
    begin
      tchar         = 6'h21;  // pulse goes ahead of queued characters
      pulse_pending = 1'b0;
    end
    else if (tag_q.size() > 0)
      tchar = tag_q.pop_front();
    else
      tchar = 6'h20;          // empty FIFO sends a space
    model_frame = 4'(frame_n);
    cmd         = n_cmd;
    len         = 4'(n_len);
    sync        = 1'b1;
    step();
    sync = 1'b0;
    while (adxl_csn)
      step();
    while (!adxl_csn)
    begin
      if (go_direct)
        direct = 1'b1;        // request arrives mid frame
      check(32'(direct_en), 32'd0, "direct_en while csn low");
      step();
    end
    check(32'(direct_en), 32'd0, "direct_en at csn rise");
    repeat (n_len + 8)        // end tick, frame_done, len-1 replay writes
      step();
    check(32'(cmd_rx), 32'(n_cmd), "command seen by sensors");
    check(32'(wr_count), 32'(2 * (n_len - 1)), "wr_count after frame");
    for (a = 0; a < 2 * (n_len - 1); a++)
    begin
      rd_addr = 5'(a);
      step();                 // one clk read latency
      check(32'(rd_data), 32'(ref_byte(frame_n, n_len, tchar, a)),
            $sformatf("frame %0d ram byte %0d", frame_n, a));
    end
    frame_n++;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (errors == test_err0)
      $display("test %0d %s: ok", tests, name);
    else
    begin
      failed++;
      $display("test %0d %s: %0d errors", tests, name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  initial
  begin
    int         i;
    logic [4:0] wc_hold;
    sync          = 1'b0;
    direct        = 1'b0;
    tag_pulse     = 1'b0;
    tag_en        = 1'b0;
    tag           = 6'h00;
    cmd           = 8'h00;
    len           = 4'd2;
    sclk_phase    = 1'b0;   // mode 0
    sclk_polarity = 1'b0;
    host_mosi     = 1'b0;
    host_sclk     = 1'b0;
    host_csn      = 1'b1;
    rd_addr       = 5'd0;
    repeat (10)
      step();
    rst = 1'b0;
    step();

    check(32'(direct_en), 32'd0, "direct_en after reset");
    run_frame(10, 8'h11, 1'b0);
    end_test("single frame len 10");

    for (i = 0; i < 6; i++)
    begin
      rnd = lcg(rnd);
      run_frame(2 + int'(rnd[23:16]) % 9, rnd[31:24], 1'b0);
    end
    end_test("random lengths");

    for (i = 0; i < 3; i++)
    begin
      rnd = lcg(rnd);
      push_tag(rnd[21:16]);
    end
    step();
    for (i = 0; i < 4; i++)
      run_frame(10, 8'h11, 1'b0); // three characters, then a space
    end_test("tag FIFO order");

    for (i = 0; i < 2; i++)
    begin
      rnd = lcg(rnd);
      push_tag(rnd[21:16]);
    end
    tag_pulse = 1'b1;
    step();
    tag_pulse     = 1'b0;
    pulse_pending = 1'b1;
    for (i = 0; i < 3; i++)
      run_frame(10, 8'h11, 1'b0);
    end_test("tag pulse priority");

    run_frame(7, 8'h11, 1'b1);
    while (!direct_en)
      step();
    wc_hold = wr_count;
    len     = 4'd3;           // a frame started now would leave 4 bytes
    sync    = 1'b1;
    step();
    sync = 1'b0;
    repeat (frame_clks)
      step();
    check(32'(wr_count), 32'(wc_hold), "wr_count after sync in direct mode");
    host_csn  = 1'b0;
    host_sclk = 1'b1;
    host_mosi = 1'b1;
    step();
    check(32'(adxl_csn), 32'd0, "adxl_csn from host");
    check(32'(adxl_sclk), 32'd1, "adxl_sclk from host");
    check(32'(adxl_mosi), 32'd1, "adxl_mosi from host");
    check(32'(host_miso), 32'(adxl0_miso), "host_miso from chip 0");
    host_sclk = 1'b0;
    host_mosi = 1'b0;
    step();
    check(32'(adxl_sclk), 32'd0, "adxl_sclk from host");
    check(32'(adxl_mosi), 32'd0, "adxl_mosi from host");
    check(32'(host_miso), 32'(adxl0_miso), "host_miso from chip 0");
    host_csn = 1'b1;
    step();
    check(32'(adxl_csn), 32'd1, "adxl_csn from host");
    check(32'(host_miso), 32'(adxl0_miso), "host_miso from deselected chip 0");
    end_test("direct mode grant");

    direct = 1'b0;
    while (direct_en)
      step();
    run_frame(10, 8'h11, 1'b0);
    end_test("direct mode release");

    $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
             tests, failed, checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- tb/adxl_sensor_model.sv
// ADXL355 pair model
// two mode-0 SPI slaves on one bus, record the command, return frame-coded bytes
`timescale 1ns/1ps

module adxl_sensor_model
(
  input  logic       csn,
  input  logic       sclk,
  input  logic       mosi,
  input  logic [3:0] frame_no,  // selects the data pattern
  output logic       miso0,
  output logic       miso1,
  output logic [7:0] cmd_rx     // last command byte received
);

  logic [6:0] bit_cnt = 7'd0;   // bit position within the frame
  logic [7:0] cmd_sr  = 8'h00;
  logic [7:0] cmd_q   = 8'h00;
  logic [7:0] tx0, tx1;

  // slot 0 answers the command byte, data byte k sits in slot k+1
  function automatic logic [7:0] tx_byte(input logic chip, input logic [3:0] nbyte,
                                         input logic [3:0] frame);
    if (nbyte == 4'd0)
      return 8'hE5;                                   // device id
    return {chip, 7'd0} + {frame, 4'h0} + {4'h0, nbyte - 4'd1};
  endfunction

  always @(posedge csn or negedge sclk)
  begin
    if (csn)
      bit_cnt <= 7'd0;
    else
      bit_cnt <= bit_cnt + 7'd1;  // mode 0, data moves on the falling edge
  end

  always @(posedge sclk)
  begin
    if (!csn && bit_cnt < 7'd8)
    begin
      cmd_sr <= {cmd_sr[6:0], mosi}; // msb first
      if (bit_cnt == 7'd7)
        cmd_q <= {cmd_sr[6:0], mosi};
    end
  end

  assign cmd_rx = cmd_q;

  always_comb
  begin
    tx0   = tx_byte(1'b0, bit_cnt[6:3], frame_no);
    tx1   = tx_byte(1'b1, bit_cnt[6:3], frame_no);
    miso0 = !csn & tx0[~bit_cnt[2:0]];
    miso1 = !csn & tx1[~bit_cnt[2:0]];
  end

endmodule
